//--- build.f
fetch_pkg.sv
fetch_predecode.sv
fetch_unit.sv
mem_arbiter.sv
insn_mem.sv
fetch_top.sv
tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fetch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_fetch.sv
`timescale 1ns/1ps
// --------------------------------------
// Fetch subsystem testbench
// Random programs, data port traffic,
// interrupts and redirects against a model
// --------------------------------------
module tb_fetch import fetch_pkg::*; ();

   localparam int TESTS = 5;

   logic           clk;
   logic           rst_n;
   logic           run;
   logic           irq;
   logic [PCW-1:0] epc;
   logic           redir_valid;
   logic [PCW-1:0] redir_tgt;
   logic           dport_req;
   logic           dport_we;
   logic [PCW-1:0] dport_addr;
   logic [IW-1:0]  dport_wdata;
   logic           dport_rvalid;
   logic [IW-1:0]  dport_rdata;
   logic           insn_valid;
   logic           insn_ready;
   logic [IW-1:0]  insn;
   logic [PCW-1:0] insn_pc;
   logic           op_jmprel;
   logic           jmprel_link;
   logic           op_syscall;
   logic           op_ret;
   logic           exc_irq;

   // Reference memory and architectural PC
   logic [IW-1:0]  model_mem [MEM_WORDS];
   logic [PCW-1:0] model_pc;
   // Expected data port read results, oldest first
   logic [IW-1:0]  rd_exp [$];
   bit             irq_pending;
   bit             last_valid;
   int             delivered;
   int             errors;
   int             passed;
   integer         seed;

   fetch_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Random word, jumps and exceptions mixed in with ordinary opcodes
   function automatic logic [IW-1:0] gen_insn(input bit with_sys);
      int             kind;
      int             off;
      logic [OPW-1:0] op;
      kind = rand_below(16);
      off  = rand_below(31) - 15;
      if (off == 0)
         off = 2;
      case (kind)
         0, 1: op = OP_JMPREL;
         2: op = OP_JMPREL_LINK;
         3: op = with_sys ? OP_SYSCALL : OP_NOP;
         4: op = with_sys ? OP_RET : OP_NOP;
         5: op = OP_NOP;
         default: op = OPW'(5 + rand_below(59));
      endcase
      return {op, 10'(rand_below(1024)), OFFW'(off)};
   endfunction

   // One decode transfer against the model, then step the model PC
   task automatic check_transfer();
      logic [IW-1:0]  w;
      logic [4:0]     flags;
      logic [PCW-1:0] nxt;
      logic [PCW-1:0] jump_tgt;
      w        = model_mem[model_pc[MEM_AW-1:0]];
      flags    = 5'b00000;
      nxt      = model_pc + 1'b1;
      jump_tgt = PCW'(int'(model_pc) + int'($signed(w[OFFW-1:0])));
      if (irq_pending) begin
         // Interrupted word is not executed
         flags       = 5'b00001;
         nxt         = IRQ_VECTOR;
         irq_pending = 1'b0;
      end else begin
         case (w[IW-1 -: OPW])
            OP_JMPREL: begin
               flags = 5'b10000;
               nxt   = jump_tgt;
            end
            OP_JMPREL_LINK: begin
               flags = 5'b11000;
               nxt   = jump_tgt;
            end
            OP_SYSCALL: begin
               flags = 5'b00100;
               nxt   = SYSCALL_VECTOR;
            end
            OP_RET: begin
               flags = 5'b00010;
               nxt   = epc;
            end
            default: ;
         endcase
      end
      check_equal(insn_pc, model_pc, "insn_pc");
      check_equal(insn, w, "insn");
      check_equal({op_jmprel, jmprel_link, op_syscall, op_ret, exc_irq}, flags,
                  "predecode flags");
      model_pc = nxt;
      delivered++;
   endtask

   // Outputs sampled late in the cycle, inputs long settled
   always @(posedge clk) begin
      #3;
      last_valid = insn_valid;
      if (rst_n) begin
         if (insn_valid && insn_ready)
            check_transfer();
         if (dport_rvalid) begin
            if (rd_exp.size() == 0) begin
               $display("read data returned at %0t ns with no read outstanding", $time);
               errors++;
            end else
               check_equal(dport_rdata, rd_exp.pop_front(), "dport_rdata");
         end
         // Redirect target is the next delivered PC
         if (redir_valid)
            model_pc = redir_tgt;
      end
   end

   // Drive point of the next cycle, strobes back to idle
   task automatic next_cycle();
      @(posedge clk);
      #1;
      dport_req   = 1'b0;
      redir_valid = 1'b0;
   endtask

   task automatic write_word(input logic [PCW-1:0] addr, input logic [IW-1:0] data);
      dport_req   = 1'b1;
      dport_we    = 1'b1;
      dport_addr  = addr;
      dport_wdata = data;
      model_mem[addr[MEM_AW-1:0]] = data;
   endtask

   task automatic read_word(input logic [PCW-1:0] addr);
      dport_req  = 1'b1;
      dport_we   = 1'b0;
      dport_addr = addr;
      rd_exp.push_back(model_mem[addr[MEM_AW-1:0]]);
   endtask

   // Whole memory through the data port
   task automatic load_program(input bit with_sys);
      for (int a = 0; a < MEM_WORDS; a++) begin
         next_cycle();
         write_word(PCW'(a), gen_insn(with_sys));
      end
      next_cycle();
   endtask

   task automatic wait_reads();
      int waited;
      waited = 0;
      while (rd_exp.size() != 0 && waited < 10) begin
         next_cycle();
         waited++;
      end
      if (rd_exp.size() != 0) begin
         $display("timeout: %0d data port reads never returned", rd_exp.size());
         errors++;
      end
   endtask

   // Run until count more transfers, with random ready, reads and redirects
   task automatic run_until(input int count, input int ready_pct, input int read_pct,
                            input int redir_pct);
      int target;
      int waited;
      target = delivered + count;
      waited = 0;
      run    = 1'b1;
      while (delivered < target && waited < count * 30 + 200) begin
         next_cycle();
         waited++;
         insn_ready = (rand_below(100) < ready_pct);
         if (rand_below(100) < read_pct)
            read_word(PCW'(rand_below(1 << PCW)));
         if (rand_below(100) < redir_pct) begin
            redir_valid = 1'b1;
            redir_tgt   = PCW'(rand_below(1 << PCW));
         end
      end
      next_cycle();
      if (delivered < target) begin
         $display("timeout after %0d cycles waiting for %0d instructions", waited, count);
         errors++;
      end
   endtask

   // Stop fetching and empty the queue, three idle cycles in a row
   task automatic drain();
      int quiet;
      int waited;
      run        = 1'b0;
      insn_ready = 1'b1;
      quiet      = 0;
      waited     = 0;
      while (quiet < 3 && waited < 50) begin
         next_cycle();
         waited++;
         quiet = last_valid ? 0 : quiet + 1;
      end
      if (quiet < 3) begin
         $display("timeout: decode output did not go idle with run low");
         errors++;
      end
   endtask

   task automatic end_test(input int num, input string name, input int errs_before);
      if (errors == errs_before) begin
         passed++;
         $display("test %0d %s: pass", num, name);
      end else
         $display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
   endtask

   initial begin
      int             mark;
      logic [PCW-1:0] addrs [32];
      seed        = 94;
      rst_n       = 1'b0;
      run         = 1'b0;
      irq         = 1'b0;
      epc         = RESET_PC;
      redir_valid = 1'b0;
      redir_tgt   = '0;
      dport_req   = 1'b0;
      dport_we    = 1'b0;
      dport_addr  = '0;
      dport_wdata = '0;
      insn_ready  = 1'b0;
      model_pc    = RESET_PC;
      irq_pending = 1'b0;
      last_valid  = 1'b0;
      delivered   = 0;
      errors      = 0;
      passed      = 0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Data port only, fetch idle
      mark = errors;
      for (int i = 0; i < 32; i++) begin
         next_cycle();
         addrs[i] = PCW'(rand_below(1 << PCW));
         write_word(addrs[i], IW'($random(seed)));
      end
      for (int i = 0; i < 32; i++) begin
         next_cycle();
         read_word(addrs[i]);
      end
      next_cycle();
      wait_reads();
      end_test(1, "load and read-back", mark);

      mark = errors;
      load_program(1'b0);
      run_until(300, 100, 0, 0);
      drain();
      end_test(2, "straight-line and jump flow", mark);

      mark = errors;
      load_program(1'b1);
      epc = PCW'(rand_below(MEM_WORDS));
      for (int i = 0; i < 6; i++) begin
         run_until(3 + rand_below(12), 100, 0, 0);
         drain();
         // Pipeline empty, so the next kept word takes the interrupt
         irq_pending = 1'b1;
         irq         = 1'b1;
         run         = 1'b1;
         next_cycle();
         next_cycle();
         irq = 1'b0;
      end
      run_until(200, 100, 0, 0);
      drain();
      end_test(3, "syscall, return and interrupt", mark);

      mark = errors;
      run_until(300, 60, 25, 0);
      drain();
      wait_reads();
      end_test(4, "back-pressure and contention", mark);

      mark = errors;
      run_until(300, 80, 10, 4);
      drain();
      wait_reads();
      end_test(5, "redirect", mark);

      $display("summary: %0d of %0d tests clean, %0d errors", passed, TESTS, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps
// --------------------------------------
// Fetch subsystem top
// Fetch unit and data port sharing one
// instruction memory through the arbiter
// --------------------------------------
module fetch_top import fetch_pkg::*; (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           run,
   input  logic           irq,
   input  logic [PCW-1:0] epc,
   input  logic           redir_valid,
   input  logic [PCW-1:0] redir_tgt,
   input  logic           dport_req,
   input  logic           dport_we,
   input  logic [PCW-1:0] dport_addr,
   input  logic [IW-1:0]  dport_wdata,
   output logic           dport_rvalid,
   output logic [IW-1:0]  dport_rdata,
   output logic           insn_valid,
   input  logic           insn_ready,
   output logic [IW-1:0]  insn,
   output logic [PCW-1:0] insn_pc,
   output logic           op_jmprel,
   output logic           jmprel_link,
   output logic           op_syscall,
   output logic           op_ret,
   output logic           exc_irq
);

   // Fetch command and response
   logic           fcmd_valid;
   logic           fcmd_ready;
   logic [PCW-1:0] fcmd_addr;
   logic           frsp_valid;
   logic [IW-1:0]  frsp_data;
   logic [PCW-1:0] frsp_id;
   // Memory port
   logic           mem_en;
   logic           mem_we;
   logic [PCW-1:0] mem_addr;
   logic [IW-1:0]  mem_wdata;
   logic [IW-1:0]  mem_rdata;

   fetch_unit u_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .run         (run),
      .irq         (irq),
      .epc         (epc),
      .redir_valid (redir_valid),
      .redir_tgt   (redir_tgt),
      .fcmd_ready  (fcmd_ready),
      .frsp_valid  (frsp_valid),
      .frsp_data   (frsp_data),
      .frsp_id     (frsp_id),
      .insn_ready  (insn_ready),
      .fcmd_valid  (fcmd_valid),
      .fcmd_addr   (fcmd_addr),
      .insn_valid  (insn_valid),
      .insn        (insn),
      .insn_pc     (insn_pc),
      .op_jmprel   (op_jmprel),
      .jmprel_link (jmprel_link),
      .op_syscall  (op_syscall),
      .op_ret      (op_ret),
      .exc_irq     (exc_irq)
   );

   mem_arbiter u_arb (
      .clk          (clk),
      .rst_n        (rst_n),
      .dport_req    (dport_req),
      .dport_we     (dport_we),
      .dport_addr   (dport_addr),
      .dport_wdata  (dport_wdata),
      .fcmd_valid   (fcmd_valid),
      .fcmd_addr    (fcmd_addr),
      .mem_rdata    (mem_rdata),
      .fcmd_ready   (fcmd_ready),
      .frsp_valid   (frsp_valid),
      .frsp_data    (frsp_data),
      .frsp_id      (frsp_id),
      .dport_rvalid (dport_rvalid),
      .dport_rdata  (dport_rdata),
      .mem_en       (mem_en),
      .mem_we       (mem_we),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata)
   );

   insn_mem u_mem (
      .clk   (clk),
      .en    (mem_en),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

endmodule

//--- insn_mem.sv
`timescale 1ns/1ps
// --------------------------------------
// Instruction memory
// Single port, one-cycle registered read
// --------------------------------------
module insn_mem import fetch_pkg::*; (
   input  logic           clk,
   input  logic           en,
   input  logic           we,
   input  logic [PCW-1:0] addr,
   input  logic [IW-1:0]  wdata,
   output logic [IW-1:0]  rdata
);

   logic [IW-1:0]    mem [MEM_WORDS];
   logic [MEM_AW-1:0] idx;

   // Upper word address bits alias
   assign idx = addr[MEM_AW-1:0];

   always_ff @(posedge clk) begin
      if (en) begin
         if (we)
            mem[idx] <= wdata;
         else
            rdata <= mem[idx];
      end
   end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps
// --------------------------------------
// Memory port arbiter
// Data port first, fetch otherwise, and
// one-cycle responses steered back
// --------------------------------------
module mem_arbiter import fetch_pkg::*; (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           dport_req,
   input  logic           dport_we,
   input  logic [PCW-1:0] dport_addr,
   input  logic [IW-1:0]  dport_wdata,
   input  logic           fcmd_valid,
   input  logic [PCW-1:0] fcmd_addr,
   input  logic [IW-1:0]  mem_rdata,
   output logic           fcmd_ready,
   output logic           frsp_valid,
   output logic [IW-1:0]  frsp_data,
   output logic [PCW-1:0] frsp_id,
   output logic           dport_rvalid,
   output logic [IW-1:0]  dport_rdata,
   output logic           mem_en,
   output logic           mem_we,
   output logic [PCW-1:0] mem_addr,
   output logic [IW-1:0]  mem_wdata
);

   gnt_e           gnt;
   gnt_e           rsp_tag;
   logic [PCW-1:0] rsp_id;

   // Fixed priority, data port never waits
   assign gnt = dport_req ? GNT_DATA : (fcmd_valid ? GNT_FETCH : GNT_NONE);
   assign fcmd_ready = !dport_req;

   assign mem_en    = (gnt != GNT_NONE);
   assign mem_we    = (gnt == GNT_DATA) && dport_we;
   assign mem_addr  = (gnt == GNT_DATA) ? dport_addr : fcmd_addr;
   assign mem_wdata = dport_wdata;

   // Writes return nothing, so no tag for them
   always_ff @(posedge clk) begin
      if (!rst_n)
         rsp_tag <= GNT_NONE;
      else
         rsp_tag <= mem_we ? GNT_NONE : gnt;
   end

   // Fetched address comes back as the id
   always_ff @(posedge clk) begin
      rsp_id <= fcmd_addr;
   end

   assign frsp_valid   = (rsp_tag == GNT_FETCH);
   assign frsp_data    = mem_rdata;
   assign frsp_id      = rsp_id;
   assign dport_rvalid = (rsp_tag == GNT_DATA);
   assign dport_rdata  = mem_rdata;

   // Data read answers next cycle, with no fetch response beside it
   a_data_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      dport_req && !dport_we |=> dport_rvalid && !frsp_valid);
   a_fetch_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      fcmd_valid && fcmd_ready |=> frsp_valid && frsp_id == $past(fcmd_addr));

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps
// --------------------------------------
// Fetch unit
// PC and credit tracking, response filter
// and a small queue toward decode
// --------------------------------------
module fetch_unit import fetch_pkg::*; (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           run,
   input  logic           irq,
   input  logic [PCW-1:0] epc,
   input  logic           redir_valid,
   input  logic [PCW-1:0] redir_tgt,
   input  logic           fcmd_ready,
   input  logic           frsp_valid,
   input  logic [IW-1:0]  frsp_data,
   input  logic [PCW-1:0] frsp_id,
   input  logic           insn_ready,
   output logic           fcmd_valid,
   output logic [PCW-1:0] fcmd_addr,
   output logic           insn_valid,
   output logic [IW-1:0]  insn,
   output logic [PCW-1:0] insn_pc,
   output logic           op_jmprel,
   output logic           jmprel_link,
   output logic           op_syscall,
   output logic           op_ret,
   output logic           exc_irq
);

   logic [PCW-1:0] pc;
   logic [PCW-1:0] expect_pc;
   logic [QCW-1:0] credits;
   // Queue slots, flags packed as {jmprel, link, syscall, ret, irq}
   logic [IW-1:0]  q_insn [QDEPTH];
   logic [PCW-1:0] q_pc [QDEPTH];
   logic [4:0]     q_flags [QDEPTH];
   logic [QPW-1:0] q_rd_ptr;
   logic [QPW-1:0] q_wr_ptr;
   logic [QCW-1:0] q_count;
   logic           pd_jmprel;
   logic           pd_link;
   logic           pd_syscall;
   logic           pd_ret;
   logic           pd_irq;
   logic [PCW-1:0] pd_offset;
   logic [PCW-1:0] next_pc;
   logic           issue;
   logic           keep;
   logic           drop;
   logic           q_wr;
   logic           xfer;
   logic           flow_change;

   fetch_predecode u_predecode (
      .insn          (frsp_data),
      .irq           (irq),
      .op_jmprel     (pd_jmprel),
      .jmprel_link   (pd_link),
      .op_syscall    (pd_syscall),
      .op_ret        (pd_ret),
      .exc_irq       (pd_irq),
      .jmprel_offset (pd_offset)
   );

   // Issue only with a free credit
   assign fcmd_valid = run && (credits < QCW'(QDEPTH));
   assign fcmd_addr  = pc;
   assign issue      = fcmd_valid && fcmd_ready;

   // Filter keeps only the next word on the correct path
   assign keep = frsp_valid && (frsp_id == expect_pc);
   assign drop = frsp_valid && !keep;
   assign q_wr = keep && !redir_valid;
   assign xfer = insn_valid && insn_ready;

   // Successor of a kept word, interrupt first
   assign next_pc = pd_irq ? IRQ_VECTOR :
                    pd_syscall ? SYSCALL_VECTOR :
                    pd_ret ? epc :
                    pd_jmprel ? frsp_id + pd_offset :
                    frsp_id + 1'b1;
   assign flow_change = keep && (pd_irq || pd_syscall || pd_ret || pd_jmprel);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc        <= RESET_PC;
         expect_pc <= RESET_PC;
         credits   <= '0;
         q_rd_ptr  <= '0;
         q_wr_ptr  <= '0;
         q_count   <= '0;
      end else if (redir_valid) begin
         pc        <= redir_tgt;
         expect_pc <= redir_tgt;
         // Fetch accepted now is still owed a credit
         credits   <= QCW'(issue);
         q_rd_ptr  <= '0;
         q_wr_ptr  <= '0;
         q_count   <= '0;
      end else begin
         if (flow_change)
            pc <= next_pc;
         else if (issue)
            pc <= pc + 1'b1;
         if (keep)
            expect_pc <= next_pc;
         credits <= credits + QCW'(issue) - QCW'(xfer) - QCW'(drop);
         q_count <= q_count + QCW'(q_wr) - QCW'(xfer);
         if (q_wr)
            q_wr_ptr <= (q_wr_ptr == QPW'(QDEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
         if (xfer)
            q_rd_ptr <= (q_rd_ptr == QPW'(QDEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
      end
   end

   // Queue payload
   always_ff @(posedge clk) begin
      if (q_wr) begin
         q_insn[q_wr_ptr]  <= frsp_data;
         q_pc[q_wr_ptr]    <= frsp_id;
         q_flags[q_wr_ptr] <= {pd_jmprel, pd_link, pd_syscall, pd_ret, pd_irq};
      end
   end

   // Head of queue toward decode, dropped during a redirect
   assign insn_valid = (q_count != '0) && !redir_valid;
   assign insn       = q_insn[q_rd_ptr];
   assign insn_pc    = q_pc[q_rd_ptr];
   assign {op_jmprel, jmprel_link, op_syscall, op_ret, exc_irq} = q_flags[q_rd_ptr];

   a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= QCW'(QDEPTH));
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      !(q_wr && q_count == QCW'(QDEPTH)));
   // Queue is empty the cycle after a redirect
   a_redir_blocks: assert property (@(posedge clk) disable iff (!rst_n)
      redir_valid |=> !insn_valid);

endmodule

//--- fetch_predecode.sv
`timescale 1ns/1ps
// --------------------------------------
// Instruction predecoder
// Flags jumps, syscalls, returns and
// interrupts, extracts the jump offset
// --------------------------------------
module fetch_predecode import fetch_pkg::*; (
   input  logic [IW-1:0]  insn,
   input  logic           irq,
   output logic           op_jmprel,
   output logic           jmprel_link,
   output logic           op_syscall,
   output logic           op_ret,
   output logic           exc_irq,
   output logic [PCW-1:0] jmprel_offset
);

   opcode_e op;

   // Opcode sits in the top bits
   assign op = opcode_e'(insn[IW-1 -: OPW]);

   // Signed word offset, resized to the PC width
   assign jmprel_offset = PCW'(signed'(insn[OFFW-1:0]));

   always_comb begin
      op_jmprel   = 1'b0;
      jmprel_link = 1'b0;
      op_syscall  = 1'b0;
      op_ret      = 1'b0;
      // Interrupt wins, the word is not executed
      exc_irq     = irq;
      if (!irq) begin
         case (op)
            OP_JMPREL: op_jmprel = 1'b1;
            OP_JMPREL_LINK: begin
               op_jmprel   = 1'b1;
               jmprel_link = 1'b1;
            end
            OP_SYSCALL: op_syscall = 1'b1;
            OP_RET: op_ret = 1'b1;
            default: ;
         endcase
      end
   end

endmodule

//--- fetch_pkg.sv
// --------------------------------------
// Fetch subsystem shared definitions
// Widths, vectors, memory depth, queue
// sizing and the opcode and grant enums
// --------------------------------------
package fetch_pkg;

   // Byte address and data widths
   localparam int AW = 16;
   localparam int IW = 32;
   // Word PC width
   localparam int PCW = AW - 2;

   // Memory depth and its index width
   localparam int MEM_WORDS = 1024;
   localparam int MEM_AW = $clog2(MEM_WORDS);

   // Fetch start point and exception entries, all word addresses
   localparam logic [PCW-1:0] RESET_PC = '0;
   localparam logic [PCW-1:0] SYSCALL_VECTOR = PCW'(16'h0040 >> 2);
   localparam logic [PCW-1:0] IRQ_VECTOR = PCW'(16'h0080 >> 2);

   // Relative jump offset field
   localparam int OFFW = 16;
   // Opcode field in the top bits
   localparam int OPW = 6;

   // Output queue depth, also the credit limit
   localparam int QDEPTH = 2;
   localparam int QCW = $clog2(QDEPTH + 1);
   localparam int QPW = $clog2(QDEPTH);

   // Other opcode values are ordinary instructions
   typedef enum logic [OPW-1:0] {
      OP_NOP         = 6'd0,
      OP_JMPREL      = 6'd1,
      OP_JMPREL_LINK = 6'd2,
      OP_SYSCALL     = 6'd3,
      OP_RET         = 6'd4
   } opcode_e;

   // Memory port owner, also the pending response tag
   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_DATA,
      GNT_FETCH
   } gnt_e;

endpackage
